//--- logic/aes_gf_pkg.sv
`default_nettype none

package aes_gf_pkg;

        typedef logic [7:0] aes_byte_t;

        // byte i sits in column i/4, row i%4, byte 0 lowest
        typedef union packed {
                aes_byte_t [15:0] bytes;
                logic [3:0][31:0] cols;
        } aes_block_u;

        typedef logic [127:0] aes_key_t;

        function automatic aes_byte_t xtime(input aes_byte_t a);
                return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        endfunction

        // reduction by 0x11b
        function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
                aes_byte_t p;
                aes_byte_t s;
                p = 8'h00;
                s = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                p = p ^ s;
                        s = xtime(s);
                end
                return p;
        endfunction

        // a^254, so zero maps to zero
        function automatic aes_byte_t gf_inv(input aes_byte_t a);
                aes_byte_t r;
                aes_byte_t p;
                r = 8'h01;
                p = a;
                for (int i = 1; i < 8; i++) begin
                        p = gf_mul(p, p);
                        r = gf_mul(r, p);
                end
                return r;
        endfunction

        // key rounds 1 to 10
        function automatic aes_byte_t rcon(input logic [3:0] rnd);
                aes_byte_t r;
                r = 8'h01;
                for (int i = 2; i <= 10; i++) begin
                        if (i <= rnd)
                                r = xtime(r);
                end
                return r;
        endfunction

        function automatic aes_byte_t rotl(input aes_byte_t a, input int n);
                return (a << n) | (a >> (8 - n));
        endfunction

        function automatic aes_byte_t sbox(input aes_byte_t a);
                aes_byte_t b;
                b = gf_inv(a);
                return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ 8'h63;
        endfunction

        // undo the affine map first, then invert
        function automatic aes_byte_t inv_sbox(input aes_byte_t a);
                aes_byte_t x;
                x = rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05;
                return gf_inv(x);
        endfunction

endpackage

`default_nettype wire

//--- logic/aes_inv_pkg.sv
`default_nettype none

package aes_inv_pkg;

        localparam int num_rounds = 10;
        localparam int num_keys = num_rounds + 1;  // round keys 0..10

        typedef logic [3:0] key_idx_t;

        // datapath action for the current cycle
        typedef enum logic [2:0] {
                step_none,
                step_load,
                step_first,
                step_mid,
                step_last
        } round_step_e;

        typedef struct packed {
                aes_gf_pkg::aes_block_u block;
                aes_gf_pkg::aes_key_t   key;
        } aes_req_t;

        typedef struct packed {
                round_step_e step;
                key_idx_t    key_idx;
        } dp_cmd_t;

endpackage

`default_nettype wire

//--- logic/aes_inv_mix_columns.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_mix_columns (
        input  aes_gf_pkg::aes_block_u  mix_in,
        output aes_gf_pkg::aes_block_u  mix_out
);

        // first row of the circulant matrix
        localparam aes_gf_pkg::aes_byte_t coef [4] = '{8'h0e, 8'h0b, 8'h0d, 8'h09};

        always_comb begin
                aes_gf_pkg::aes_byte_t acc;
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                acc = 8'h00;
                                for (int k = 0; k < 4; k++)
                                        acc = acc ^ aes_gf_pkg::gf_mul(coef[(k - r + 4) % 4],
                                                                       mix_in.cols[c][8*k +: 8]);
                                mix_out.cols[c][8*r +: 8] = acc;
                        end
                end
        end

endmodule

`default_nettype wire

//--- logic/aes_inv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_datapath (
        input  logic                    clk,
        input  logic                    rst,
        input  aes_inv_pkg::dp_cmd_t    cmd,
        input  aes_gf_pkg::aes_block_u  block_in,
        input  aes_gf_pkg::aes_key_t    round_key,
        output aes_gf_pkg::aes_block_u  state
);

        aes_gf_pkg::aes_block_u mix_in;
        aes_gf_pkg::aes_block_u mix_out;

        // row r takes its byte from column c - r
        always_comb begin
                int src;
                for (int i = 0; i < 16; i++) begin
                        src = 4 * ((i / 4 - i % 4 + 4) % 4) + i % 4;
                        mix_in.bytes[i] = aes_gf_pkg::inv_sbox(state.bytes[src])
                                          ^ round_key[8*i +: 8];
                end
        end

        aes_inv_mix_columns u_mix (
                .mix_in  (mix_in),
                .mix_out (mix_out)
        );

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= '0;
                end else begin
                        case (cmd.step)
                        aes_inv_pkg::step_load:  state <= block_in;
                        aes_inv_pkg::step_first: state <= state ^ round_key;
                        aes_inv_pkg::step_mid:   state <= mix_out;
                        aes_inv_pkg::step_last:  state <= mix_in;   // final round skips mixing
                        default:                 state <= state;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- logic/aes_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   key_load,
        input  logic                   key_expand,
        input  aes_gf_pkg::aes_key_t   cipher_key,
        input  aes_inv_pkg::key_idx_t  rd_idx,
        output aes_gf_pkg::aes_key_t   round_key
);

        aes_gf_pkg::aes_key_t   keys [aes_inv_pkg::num_keys];
        aes_gf_pkg::aes_key_t   prev_key;   // seeds the next expansion
        aes_gf_pkg::aes_key_t   next_key;
        aes_inv_pkg::key_idx_t  wr_idx;
        logic [31:0]            rot_word;
        logic [31:0]            sub_word;

        // last word rotated by one byte
        assign rot_word = {prev_key[103:96], prev_key[127:104]};

        always_comb begin
                for (int b = 0; b < 4; b++)
                        sub_word[8*b +: 8] = aes_gf_pkg::sbox(rot_word[8*b +: 8]);
                sub_word[7:0] = sub_word[7:0] ^ aes_gf_pkg::rcon(wr_idx);
                next_key[31:0] = prev_key[31:0] ^ sub_word;
                next_key[63:32] = prev_key[63:32] ^ next_key[31:0];     // xor chain
                next_key[95:64] = prev_key[95:64] ^ next_key[63:32];
                next_key[127:96] = prev_key[127:96] ^ next_key[95:64];
        end

        always_ff @(posedge clk) begin
                if (rst)
                        wr_idx <= '0;
                else if (key_load)
                        wr_idx <= 4'd1;
                else if (key_expand)
                        wr_idx <= wr_idx + 4'd1;
        end

        always_ff @(posedge clk) begin
                if (key_load) begin
                        keys[0] <= cipher_key;
                        prev_key <= cipher_key;
                end else if (key_expand) begin
                        keys[wr_idx] <= next_key;
                        prev_key <= next_key;
                end
        end

        assign round_key = keys[rd_idx];

endmodule

`default_nettype wire

//--- logic/aes_inv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_ctrl (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  start,
        output logic                  key_load,
        output logic                  key_expand,
        output aes_inv_pkg::dp_cmd_t  cmd,
        output logic                  done
);

        localparam aes_inv_pkg::key_idx_t last_idx =
                aes_inv_pkg::key_idx_t'(aes_inv_pkg::num_rounds);

        typedef enum logic [2:0] {
                st_idle,
                st_expand,
                st_first,
                st_rounds,
                st_finish
        } ctrl_state_e;

        ctrl_state_e            state;
        aes_inv_pkg::key_idx_t  cnt;    // key being expanded
        aes_inv_pkg::key_idx_t  rnd;    // counts down from 10
        logic                   accept;

        assign accept = start && (state == st_idle);
        assign key_load = accept;
        assign key_expand = (state == st_expand);

        always_comb begin
                cmd.key_idx = rnd;
                case (state)
                st_idle:   cmd.step = accept ? aes_inv_pkg::step_load : aes_inv_pkg::step_none;
                st_first:  cmd.step = aes_inv_pkg::step_first;
                st_rounds: cmd.step = aes_inv_pkg::step_mid;
                st_finish: cmd.step = aes_inv_pkg::step_last;  // key 0, no mixing
                default:   cmd.step = aes_inv_pkg::step_none;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                        cnt <= '0;
                        rnd <= '0;
                        done <= 1'b0;
                end else begin
                        done <= (state == st_finish);
                        case (state)
                        st_idle: begin
                                if (accept) begin
                                        state <= st_expand;
                                        cnt <= 4'd1;
                                        rnd <= last_idx;
                                end
                        end
                        st_expand: begin
                                cnt <= cnt + 4'd1;
                                if (cnt == last_idx)
                                        state <= st_first;
                        end
                        st_first: begin
                                rnd <= rnd - 4'd1;
                                state <= st_rounds;
                        end
                        st_rounds: begin
                                rnd <= rnd - 4'd1;
                                if (rnd == 4'd1)
                                        state <= st_finish;
                        end
                        st_finish: state <= st_idle;
                        default:   state <= st_idle;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- logic/aes_inv_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_top (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    start,
        input  aes_inv_pkg::aes_req_t   req,
        output logic                    done,
        output aes_gf_pkg::aes_block_u  plain
);

        logic                   key_load;
        logic                   key_expand;
        aes_inv_pkg::dp_cmd_t   cmd;
        aes_gf_pkg::aes_key_t   round_key;

        aes_inv_ctrl u_ctrl (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .key_load   (key_load),
                .key_expand (key_expand),
                .cmd        (cmd),
                .done       (done)
        );

        // read index follows the round being run
        aes_key_schedule u_key (
                .clk        (clk),
                .rst        (rst),
                .key_load   (key_load),
                .key_expand (key_expand),
                .cipher_key (req.key),
                .rd_idx     (cmd.key_idx),
                .round_key  (round_key)
        );

        aes_inv_datapath u_dp (
                .clk        (clk),
                .rst        (rst),
                .cmd        (cmd),
                .block_in   (req.block),
                .round_key  (round_key),
                .state      (plain)
        );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
        output logic clk
);

        // 4 ns period
        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

endmodule

`default_nettype wire

//--- sim/aes_inv_assert.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_assert (
        input logic clk,
        input logic rst,
        input logic start,
        input logic done
);

        logic busy;
        logic accept;
        int   assert_fails;

        // core is free again on the edge that shows done
        assign accept = start && (!busy || done);

        initial assert_fails = 0;

        always_ff @(posedge clk) begin
                if (rst)
                        busy <= 1'b0;
                else if (accept)
                        busy <= 1'b1;
                else if (done)
                        busy <= 1'b0;
        end

        done_single_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
                $error("done held high for two cycles");
                assert_fails++;
        end

        done_not_early: assert property (@(posedge clk) disable iff (rst)
                                         accept |=> !done [*21])
        else begin
                $error("done came within 21 cycles of an accepted start");
                assert_fails++;
        end

        done_low_after_rst: assert property (@(posedge clk) rst |=> !done)
        else begin
                $error("done high right after reset");
                assert_fails++;
        end

endmodule

`default_nettype wire

//--- include/aes_inv_model.svh
`ifndef AES_INV_MODEL_SVH
`define AES_INV_MODEL_SVH

logic [7:0] model_sbox [256];
logic [7:0] model_inv_sbox [256];

function automatic logic [7:0] double_byte(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] s;
        p = 8'h00;
        s = a;
        for (int i = 0; i < 8; i++) begin
                if (b[i])
                        p = p ^ s;
                s = double_byte(s);
        end
        return p;
endfunction

// brute-force inverse, affine map, then the inverse table by lookup
task automatic build_sbox_tables();
        logic [7:0] inv;
        logic [7:0] s;
        for (int x = 0; x < 256; x++) begin
                inv = 8'h00;
                for (int y = 1; y < 256; y++) begin
                        if (field_mul(x[7:0], y[7:0]) == 8'h01)
                                inv = y[7:0];
                end
                s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
                model_sbox[x] = s;
                model_inv_sbox[s] = x[7:0];
        end
endtask

// byte 0 at bits 7:0 for all three vectors
task automatic reference_decrypt(input logic [127:0] ct, input logic [127:0] key,
                                 output logic [127:0] pt);
        logic [127:0] rk [11];
        logic [31:0]  t;
        logic [7:0]   rc;
        logic [7:0]   st [16];
        logic [7:0]   sh [16];
        logic [7:0]   a0;
        logic [7:0]   a1;
        logic [7:0]   a2;
        logic [7:0]   a3;
        rc = 8'h01;
        rk[0] = key;
        for (int r = 1; r <= 10; r++) begin
                t = rk[r-1][127:96];
                t = {t[7:0], t[31:8]};
                t = {model_sbox[t[31:24]], model_sbox[t[23:16]],
                     model_sbox[t[15:8]], model_sbox[t[7:0]] ^ rc};
                rk[r][31:0] = rk[r-1][31:0] ^ t;
                rk[r][63:32] = rk[r-1][63:32] ^ rk[r][31:0];
                rk[r][95:64] = rk[r-1][95:64] ^ rk[r][63:32];
                rk[r][127:96] = rk[r-1][127:96] ^ rk[r][95:64];
                rc = double_byte(rc);
        end
        for (int i = 0; i < 16; i++)
                st[i] = ct[8*i +: 8] ^ rk[10][8*i +: 8];
        for (int r = 9; r >= 0; r--) begin
                // row w of column c moves right by w
                for (int c = 0; c < 4; c++) begin
                        for (int w = 0; w < 4; w++)
                                sh[4*((c + w) % 4) + w] = st[4*c + w];
                end
                for (int i = 0; i < 16; i++)
                        sh[i] = model_inv_sbox[sh[i]] ^ rk[r][8*i +: 8];
                if (r == 0) begin
                        st = sh;
                end else begin
                        for (int c = 0; c < 4; c++) begin
                                a0 = sh[4*c];
                                a1 = sh[4*c + 1];
                                a2 = sh[4*c + 2];
                                a3 = sh[4*c + 3];
                                st[4*c] = field_mul(8'h0e, a0) ^ field_mul(8'h0b, a1)
                                          ^ field_mul(8'h0d, a2) ^ field_mul(8'h09, a3);
                                st[4*c + 1] = field_mul(8'h09, a0) ^ field_mul(8'h0e, a1)
                                              ^ field_mul(8'h0b, a2) ^ field_mul(8'h0d, a3);
                                st[4*c + 2] = field_mul(8'h0d, a0) ^ field_mul(8'h09, a1)
                                              ^ field_mul(8'h0e, a2) ^ field_mul(8'h0b, a3);
                                st[4*c + 3] = field_mul(8'h0b, a0) ^ field_mul(8'h0d, a1)
                                              ^ field_mul(8'h09, a2) ^ field_mul(8'h0e, a3);
                        end
                end
        end
        for (int i = 0; i < 16; i++)
                pt[8*i +: 8] = st[i];
endtask

`endif

//--- sim/aes_inv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_tb;

        localparam int clk_period = 4;
        localparam int num_blocks = 205;        // every decryption started in the run
        localparam int watchdog_cycles = num_blocks * 30 + 100;

        logic                    clk;
        logic                    rst;
        logic                    start;
        aes_inv_pkg::aes_req_t   req;
        logic                    done;
        aes_gf_pkg::aes_block_u  plain;

        integer seed;
        int     errors;
        int     tests_run;
        int     tests_failed;

        `include "aes_inv_model.svh"

        tb_clk_gen u_clk (.clk(clk));

        aes_inv_top dut (
                .clk   (clk),
                .rst   (rst),
                .start (start),
                .req   (req),
                .done  (done),
                .plain (plain)
        );

        bind aes_inv_top aes_inv_assert u_assert (
                .clk   (clk),
                .rst   (rst),
                .start (start),
                .done  (done)
        );

        function automatic logic [127:0] rand_block();
                return {$random(seed), $random(seed), $random(seed), $random(seed)};
        endfunction

        // FIPS-197 strings list byte 0 first
        function automatic logic [127:0] fips_to_block(input logic [127:0] s);
                logic [127:0] b;
                for (int i = 0; i < 16; i++)
                        b[8*i +: 8] = s[127 - 8*i -: 8];
                return b;
        endfunction

        // call right after a rising edge
        task automatic decrypt_block(input logic [127:0] ct, input logic [127:0] key,
                                     output logic [127:0] pt, output int lat);
                start <= 1'b1;
                req <= {ct, key};       // block in the upper half
                @(posedge clk);         // edge 0 samples start
                start <= 1'b0;
                lat = 0;
                do begin
                        @(posedge clk);
                        lat++;
                end while (!done && lat < 40);
                pt = plain;
        endtask

        task automatic run_and_compare(input logic [127:0] ct, input logic [127:0] key,
                                       input logic [127:0] exp);
                logic [127:0] got;
                int           lat;
                decrypt_block(ct, key, got, lat);
                if (!done) begin
                        errors++;
                        $display("done never came within %0d cycles of a start", lat);
                end else if (got !== exp) begin
                        errors++;
                        $display("MISMATCH plain: got %h expected %h", got, exp);
                end
        endtask

        task automatic report_test(input string name, input int errs_before);
                tests_run++;
                if (errors != errs_before) begin
                        tests_failed++;
                        $display("test %s: FAILED, %0d errors", name, errors - errs_before);
                end else
                        $display("test %s: ok", name);
        endtask

        task automatic known_answer_test();
                int e0;
                e0 = errors;
                run_and_compare(fips_to_block(128'h69c4e0d86a7b0430d8cdb78070b4c55a),
                                fips_to_block(128'h000102030405060708090a0b0c0d0e0f),
                                fips_to_block(128'h00112233445566778899aabbccddeeff));
                report_test("known_answer", e0);
        endtask

        task automatic random_blocks_test();
                logic [127:0] ct;
                logic [127:0] key;
                logic [127:0] exp;
                int           e0;
                e0 = errors;
                repeat (200) begin
                        ct = rand_block();
                        key = rand_block();
                        reference_decrypt(ct, key, exp);
                        run_and_compare(ct, key, exp);  // next start on the done edge
                end
                report_test("random_blocks", e0);
        endtask

        task automatic latency_test();
                logic [127:0] ct;
                logic [127:0] key;
                logic [127:0] exp;
                logic [127:0] got;
                int           lat;
                int           e0;
                e0 = errors;
                ct = rand_block();
                key = rand_block();
                reference_decrypt(ct, key, exp);
                decrypt_block(ct, key, got, lat);
                if (lat != 22) begin
                        errors++;
                        $display("done seen %0d cycles after the start, expected 22", lat);
                end
                if (got !== exp) begin
                        errors++;
                        $display("MISMATCH plain: got %h expected %h", got, exp);
                end
                @(posedge clk);
                if (done) begin
                        errors++;
                        $display("done stayed high for more than one cycle");
                end
                report_test("latency", e0);
        endtask

        task automatic busy_start_test();
                logic [127:0] ct;
                logic [127:0] key;
                logic [127:0] exp;
                logic [127:0] got;
                int           dones;
                int           e0;
                e0 = errors;
                dones = 0;
                got = '0;
                ct = rand_block();
                key = rand_block();
                reference_decrypt(ct, key, exp);
                start <= 1'b1;
                req <= {ct, key};
                for (int n = 0; n <= 40; n++) begin
                        @(posedge clk);         // edge n
                        if (done) begin
                                dones++;
                                got = plain;
                        end
                        start <= (n == 4 || n == 14);   // lands on edges 5 and 15
                        if (n == 4 || n == 14)
                                req <= {rand_block(), rand_block()};
                end
                if (dones != 1) begin
                        errors++;
                        $display("saw %0d done pulses for one accepted start", dones);
                end
                if (got !== exp) begin
                        errors++;
                        $display("MISMATCH plain: got %h expected %h", got, exp);
                end
                report_test("busy_start", e0);
        endtask

        task automatic reset_mid_test();
                logic [127:0] ct;
                logic [127:0] key;
                logic [127:0] exp;
                int           late_dones;
                int           e0;
                e0 = errors;
                late_dones = 0;
                start <= 1'b1;
                req <= {rand_block(), rand_block()};
                for (int n = 0; n <= 38; n++) begin
                        @(posedge clk);
                        start <= 1'b0;
                        if (n == 7)
                                rst <= 1'b1;    // sampled at edge 8
                        if (n == 9)
                                rst <= 1'b0;
                        if (n >= 8 && done)
                                late_dones++;
                end
                if (late_dones != 0) begin
                        errors++;
                        $display("done went high %0d times after a reset mid-run", late_dones);
                end
                ct = rand_block();
                key = rand_block();
                reference_decrypt(ct, key, exp);
                run_and_compare(ct, key, exp);
                report_test("reset_mid", e0);
        endtask

        initial begin
                int total;
                seed = 32'h68a5d312;
                errors = 0;
                tests_run = 0;
                tests_failed = 0;
                rst = 1'b1;
                start = 1'b0;
                req = '0;
                build_sbox_tables();
                repeat (5) @(posedge clk);
                rst <= 1'b0;
                known_answer_test();
                random_blocks_test();
                latency_test();
                busy_start_test();
                reset_mid_test();
                total = errors + dut.u_assert.assert_fails;
                $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                         tests_run, tests_failed, errors, dut.u_assert.assert_fails);
                if (total == 0)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

        initial begin
                #(watchdog_cycles * clk_period);
                $display("timeout, tests did not finish within %0d cycles", watchdog_cycles);
                $display("sim failed");
                $finish;
        end

endmodule

`default_nettype wire

//--- aes_inv.f
+incdir+include
logic/aes_gf_pkg.sv
logic/aes_inv_pkg.sv
logic/aes_inv_mix_columns.sv
logic/aes_inv_datapath.sv
logic/aes_key_schedule.sv
logic/aes_inv_ctrl.sv
logic/aes_inv_top.sv
sim/tb_clk_gen.sv
sim/aes_inv_assert.sv
sim/aes_inv_tb.sv
